// ==== rgmii_link_monitor.f ====
+incdir+source
source/eth_link_pkg.sv
source/rgmii_speed_detect.sv
source/rgmii_inband_decode.sv
source/link_status_merge.sv
source/rgmii_link_monitor.sv
verif/tb_rgmii_link_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the link monitor testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rgmii_link_monitor.f \
    --top-module tb_rgmii_link_monitor \
    -o tb_rgmii_link_monitor &&
./obj_dir/tb_rgmii_link_monitor | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== source/eth_link_consts.svh ====
// Constants for the RGMII link monitor, included by every block that needs speed codes or widths.
`ifndef ETH_LINK_CONSTS_SVH
`define ETH_LINK_CONSTS_SVH

// ************************************************************
// speed codes, shared by the measured and the in-band speed.
// ************************************************************
`define SPEED_10   2'b00
`define SPEED_100  2'b01
`define SPEED_1000 2'b10

// ************************************************************
// speed measurement.
// ************************************************************
// the reference counter wraps at 128 gtx_clk cycles.
`define REF_COUNT_W  7
// three edges of the divided receive clock end a measurement.
`define EDGE_COUNT_W 2
`define SYNC_STAGES  2

// number of equal status bytes in a row before the in-band status is taken.
`define INBAND_STABLE 2

`endif

// ==== source/eth_link_pkg.sv ====
// Packed types for the RGMII receive link monitor, referenced by scoped name from each block.
package eth_link_pkg;

    // ************************************************************
    // in-band status nibble, as the PHY repeats it during idle.
    // ************************************************************
    typedef struct packed {
        logic       full_duplex;  // bit 3.
        logic [1:0] speed;        // bits 2:1, same codes as the measured speed.
        logic       link_up;      // bit 0.
    } inband_status_t;

    // both nibbles of a status byte, upper nibble first.
    typedef struct packed {
        inband_status_t upper;
        inband_status_t lower;
    } inband_pair_t;

    // a received byte is either frame data or two copies of the status nibble.
    typedef union packed {
        logic [7:0]   data;
        inband_pair_t status;
    } rx_byte_u;

    // ************************************************************
    // results passed between the blocks.
    // ************************************************************
    typedef struct packed {
        logic [1:0] speed;
        logic       valid;  // one-cycle strobe.
    } speed_meas_t;

    typedef struct packed {
        inband_status_t status;
        logic           valid;  // one-cycle strobe.
    } inband_meas_t;

    typedef struct packed {
        logic [1:0] link_speed;
        logic       mii_select;      // set for 10 and 100.
        logic       link_up;
        logic       full_duplex;
        logic       speed_mismatch;  // in-band speed disagrees with the measured one.
    } link_status_t;

endpackage

// ==== source/link_status_merge.sv ====
// Merges measured speed and in-band status into the registered link status and its change pulse.
`include "eth_link_consts.svh"

module link_status_merge (
    input  logic                       gtx_clk,
    input  logic                       gtx_rst,
    input  eth_link_pkg::speed_meas_t  speed_meas,
    input  eth_link_pkg::inband_meas_t inband_meas,
    output eth_link_pkg::link_status_t link_status,
    output logic                       status_change
);

    logic [1:0]                   new_speed;
    eth_link_pkg::inband_status_t new_inband;
    eth_link_pkg::inband_status_t inband_q;
    eth_link_pkg::link_status_t   next_status;
    eth_link_pkg::link_status_t   status_q;
    logic                         change_q;

    // ************************************************************
    // next status from the strobes and the held values.
    // ************************************************************
    always_comb begin
        new_speed  = speed_meas.valid ? speed_meas.speed : status_q.link_speed;
        new_inband = inband_meas.valid ? inband_meas.status : inband_q;

        next_status.link_speed  = new_speed;
        next_status.mii_select  = (new_speed == `SPEED_10) || (new_speed == `SPEED_100);
        next_status.link_up     = new_inband.link_up;
        next_status.full_duplex = new_inband.full_duplex;
        // only meaningful while the PHY reports the link as up.
        next_status.speed_mismatch = new_inband.link_up && (new_inband.speed != new_speed);
    end

    // ************************************************************
    // registered status.
    // ************************************************************
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            inband_q <= '0;
            status_q <= '{
                link_speed:     `SPEED_1000,
                mii_select:     1'b0,
                link_up:        1'b0,
                full_duplex:    1'b0,
                speed_mismatch: 1'b0
            };
            change_q <= 1'b0;
        end else begin
            inband_q <= new_inband;
            status_q <= next_status;
            change_q <= (next_status != status_q); // lines up with the new status.
        end
    end

    assign link_status   = status_q;
    assign status_change = change_q;

    assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        link_status.mii_select == (link_status.link_speed != `SPEED_1000))
        else $error("mii_select disagrees with link_speed.");

endmodule

// ==== source/rgmii_inband_decode.sv ====
// Decodes and debounces RGMII in-band link status from idle receive bytes for the link monitor.
`include "eth_link_consts.svh"

module rgmii_inband_decode (
    input  logic                       gtx_clk,
    input  logic                       gtx_rst,
    input  eth_link_pkg::rx_byte_u     rx_byte,
    input  logic                       rx_dv,
    input  logic                       rx_er,
    output eth_link_pkg::inband_meas_t inband_meas
);

    localparam int STABLE_W = $clog2(`INBAND_STABLE + 1);

    eth_link_pkg::inband_status_t cand_status;
    eth_link_pkg::inband_status_t last_status;
    eth_link_pkg::inband_status_t held_status;
    logic                         is_cand;
    logic [STABLE_W-1:0]          stable_count;
    logic [STABLE_W-1:0]          stable_next;
    logic                         stable_hit;
    logic                         held_ok;
    logic                         valid_q;

    // ************************************************************
    // candidate detection.
    // ************************************************************
    // status is only carried between frames, with both nibbles equal.
    assign cand_status = rx_byte.status.lower;
    assign is_cand = !rx_dv && !rx_er && (rx_byte.status.upper == rx_byte.status.lower);

    always_comb begin
        if (!is_cand) begin
            stable_next = '0;                    // data or error byte breaks the run.
        end else if (stable_count != '0 && cand_status == last_status) begin
            if (stable_count == STABLE_W'(`INBAND_STABLE)) begin
                stable_next = stable_count;      // saturate while the value holds.
            end else begin
                stable_next = stable_count + 1'b1;
            end
        end else begin
            stable_next = STABLE_W'(1);          // first byte of a new run.
        end
    end

    // report once per new stable value, not on every repeat.
    assign stable_hit = (stable_next == STABLE_W'(`INBAND_STABLE)) &&
                        (!held_ok || cand_status != held_status);

    // ************************************************************
    // debounce state.
    // ************************************************************
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            stable_count <= '0;
            held_ok      <= 1'b0;
            valid_q      <= 1'b0;
        end else begin
            stable_count <= stable_next;
            valid_q      <= stable_hit;
            if (stable_hit) begin
                held_ok <= 1'b1;
            end
        end
    end

    always_ff @(posedge gtx_clk) begin
        if (is_cand) begin
            last_status <= cand_status;
        end
        if (stable_hit) begin
            held_status <= cand_status; // the value last reported.
        end
    end

    assign inband_meas = '{status: held_status, valid: valid_q};

    assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        inband_meas.valid |-> $past(!rx_dv))
        else $error("in-band status reported from a byte inside a frame.");

endmodule

// ==== source/rgmii_link_monitor.sv ====
// Top level of the RGMII receive link monitor, connecting speed measurement, in-band decode and merge.
module rgmii_link_monitor (
    input  logic                       gtx_clk,
    input  logic                       gtx_rst,
    input  logic                       rx_clk_div,
    input  eth_link_pkg::rx_byte_u     rx_byte,
    input  logic                       rx_dv,
    input  logic                       rx_er,
    output eth_link_pkg::link_status_t link_status,
    output logic                       status_change
);

    eth_link_pkg::speed_meas_t  speed_meas;
    eth_link_pkg::inband_meas_t inband_meas;

    // ************************************************************
    // the two measurements run side by side.
    // ************************************************************
    rgmii_speed_detect u_speed_detect (
        .gtx_clk    (gtx_clk),
        .gtx_rst    (gtx_rst),
        .rx_clk_div (rx_clk_div),
        .speed_meas (speed_meas)
    );

    rgmii_inband_decode u_inband_decode (
        .gtx_clk     (gtx_clk),
        .gtx_rst     (gtx_rst),
        .rx_byte     (rx_byte),
        .rx_dv       (rx_dv),
        .rx_er       (rx_er),
        .inband_meas (inband_meas)
    );

    // merged status with its change pulse.
    link_status_merge u_status_merge (
        .gtx_clk       (gtx_clk),
        .gtx_rst       (gtx_rst),
        .speed_meas    (speed_meas),
        .inband_meas   (inband_meas),
        .link_status   (link_status),
        .status_change (status_change)
    );

endmodule

// ==== source/rgmii_speed_detect.sv ====
// Measures the divided RGMII receive clock against gtx_clk and strobes a 10/100/1000 result.
`include "eth_link_consts.svh"

module rgmii_speed_detect (
    input  logic                      gtx_clk,
    input  logic                      gtx_rst,
    input  logic                      rx_clk_div,  // asynchronous to gtx_clk.
    output eth_link_pkg::speed_meas_t speed_meas
);

    logic [`SYNC_STAGES-1:0]  sync_chain;
    logic                     rx_div_last;
    logic                     rx_div_edge;
    logic [`REF_COUNT_W-1:0]  ref_count;
    logic [`EDGE_COUNT_W-1:0] edge_count;
    eth_link_pkg::speed_meas_t meas_q;

    // either transition of the synchronized bit counts as an edge.
    assign rx_div_edge = sync_chain[`SYNC_STAGES-1] ^ rx_div_last;

    // ************************************************************
    // synchronizer, edge and reference counters.
    // ************************************************************
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            sync_chain   <= '0;
            rx_div_last  <= 1'b0;
            ref_count    <= '0;
            edge_count   <= '0;
            meas_q.speed <= `SPEED_1000;
            meas_q.valid <= 1'b0;
        end else begin
            sync_chain  <= {sync_chain[`SYNC_STAGES-2:0], rx_clk_div};
            rx_div_last <= sync_chain[`SYNC_STAGES-1];
            ref_count   <= ref_count + 1'b1;
            meas_q.valid <= 1'b0;

            if (rx_div_edge) begin
                edge_count <= edge_count + 1'b1;
            end

            // no three edges within a whole reference window, so the clock is slow.
            if (&ref_count) begin
                ref_count    <= '0;
                edge_count   <= '0;
                meas_q.speed <= `SPEED_10;
                meas_q.valid <= 1'b1;
            end

            // three edges seen, the reference count tells 100 from 1000.
            if (&edge_count) begin
                ref_count    <= '0;
                edge_count   <= '0;
                meas_q.valid <= 1'b1;
                if (ref_count[`REF_COUNT_W-1 -: 2] != 2'b00) begin
                    meas_q.speed <= `SPEED_100;  // long window.
                end else begin
                    meas_q.speed <= `SPEED_1000; // short window.
                end
            end
        end
    end

    assign speed_meas = meas_q;

    // both counters restart after a result, so two strobes cannot be adjacent.
    assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        speed_meas.valid |=> !speed_meas.valid)
        else $error("speed measurement strobe held for two cycles.");

endmodule

// ==== verif/tb_rgmii_link_monitor.sv ====
// Testbench for the RGMII link monitor; drives receive clock and bytes, assertions check the status.
`include "eth_link_consts.svh"

module tb_rgmii_link_monitor;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEAS_WAIT = 300;   // two measurement windows plus synchronization.
    localparam int RUN_LIMIT = 4000;  // six tests of at most 600 cycles, with margin.

    logic                       gtx_clk = 1'b0;
    logic                       gtx_rst;
    logic                       rx_clk_div = 1'b0;
    eth_link_pkg::rx_byte_u     rx_byte;
    logic                       rx_dv;
    logic                       rx_er;
    eth_link_pkg::link_status_t link_status;
    logic                       status_change;

    int    seed;
    int    toggle_period;  // gtx_clk cycles per rx_clk_div half period, 0 holds the level.
    int    toggle_count;
    int    cycle_count;
    int    meas_count;
    int    change_count;
    int    changes;
    int    check_errors;
    int    property_errors;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    string test_name;

    rgmii_link_monitor u_dut (
        .gtx_clk       (gtx_clk),
        .gtx_rst       (gtx_rst),
        .rx_clk_div    (rx_clk_div),
        .rx_byte       (rx_byte),
        .rx_dv         (rx_dv),
        .rx_er         (rx_er),
        .link_status   (link_status),
        .status_change (status_change)
    );

    always #10 gtx_clk = ~gtx_clk;

    // ************************************************************
    // divided receive clock and event counters.
    // ************************************************************
    always @(negedge gtx_clk) begin
        if (toggle_period == 0) begin
            toggle_count <= 0;
        end else if (toggle_count >= toggle_period - 1) begin
            toggle_count <= 0;
            rx_clk_div   <= ~rx_clk_div;
        end else begin
            toggle_count <= toggle_count + 1;
        end
    end

    always @(posedge gtx_clk) begin
        cycle_count <= cycle_count + 1;
        if (!gtx_rst && u_dut.speed_meas.valid) begin
            meas_count <= meas_count + 1;  // end of one speed measurement.
        end
        if (!gtx_rst && status_change) begin
            change_count <= change_count + 1;
        end
    end

    always @(posedge gtx_clk) begin
        if (cycle_count >= RUN_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles.", RUN_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // status_change marks exactly the cycles in which link_status takes a new value.
    assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        status_change == (link_status != $past(link_status)))
        else begin
            $display("status_change does not line up with a change of link_status in %s.",
                     test_name);
            property_errors++;
        end

    assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        link_status.speed_mismatch |-> link_status.link_up)
        else begin
            $display("speed_mismatch is set while the link is down in %s.", test_name);
            property_errors++;
        end

    // ************************************************************
    // helpers.
    // ************************************************************
    function automatic eth_link_pkg::link_status_t expected_status(
        input logic [1:0] speed,
        input logic       up,
        input logic       duplex,
        input logic       mismatch
    );
        eth_link_pkg::link_status_t s;
        s.link_speed     = speed;
        s.mii_select     = (speed != `SPEED_1000);  // MII for 10 and 100.
        s.link_up        = up;
        s.full_duplex    = duplex;
        s.speed_mismatch = mismatch;
        return s;
    endfunction

    task automatic check_status(input eth_link_pkg::link_status_t expected);
        assert (link_status == expected) else begin
            $display("[ERROR] %s: link_status expected %b, actual %b",
                     test_name, expected, link_status);
            check_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        assert (actual == expected) else begin
            $display("[ERROR] %s: %s expected %b, actual %b", test_name, what, expected, actual);
            check_errors++;
        end
    endtask

    task automatic drive_byte(input logic [7:0] data, input logic dv, input logic er);
        @(negedge gtx_clk);
        rx_byte.data = data;
        rx_dv        = dv;
        rx_er        = er;
    endtask

    // idle bytes whose nibbles differ, so none of them is a status byte.
    task automatic send_filler(input int count);
        logic [7:0] b;
        repeat (count) begin
            b = 8'($random(seed));
            if (b[7:4] == b[3:0]) begin
                b[7:4] = ~b[3:0];
            end
            drive_byte(b, 1'b0, 1'b0);
        end
    endtask

    // two equal bytes; the trailing filler covers the decode and merge latency.
    task automatic send_status_pair(input logic [7:0] data, input logic dv, input logic er);
        send_filler(2);
        drive_byte(data, dv, er);
        drive_byte(data, dv, er);
        send_filler(4);
    endtask

    task automatic wait_speed_results(input int count);
        int start;
        int waited;
        start  = meas_count;
        waited = 0;
        while (meas_count < start + count && waited < MEAS_WAIT) begin
            @(negedge gtx_clk);
            waited++;
        end
        if (meas_count < start + count) begin
            $display("no speed result arrived within %0d cycles in %s.", MEAS_WAIT, test_name);
            check_errors++;
        end
        @(negedge gtx_clk);  // lets a change pulse be counted.
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = check_errors + property_errors;
    endtask

    task automatic end_test();
        int errs;
        errs = check_errors + property_errors - test_errors;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errs);
        end
    endtask

    // ************************************************************
    // test sequence.
    // ************************************************************
    initial begin
        seed          = 97;
        toggle_period = 0;
        gtx_rst       = 1'b1;
        rx_byte.data  = 8'h12;
        rx_dv         = 1'b0;
        rx_er         = 1'b0;
        test_name     = "reset";
        repeat (8) @(negedge gtx_clk);
        gtx_rst = 1'b0;

        begin_test("after_reset");
        @(negedge gtx_clk);
        check_status(expected_status(`SPEED_1000, 1'b0, 1'b0, 1'b0));
        check_flag("status_change", 1'b0, status_change);
        end_test();

        begin_test("speed_1000");
        toggle_period = 4;
        wait_speed_results(2);
        check_status(expected_status(`SPEED_1000, 1'b0, 1'b0, 1'b0));
        end_test();

        begin_test("speed_100");
        toggle_period = 20;
        wait_speed_results(2);
        check_status(expected_status(`SPEED_100, 1'b0, 1'b0, 1'b0));
        end_test();

        begin_test("speed_10");
        toggle_period = 0;
        changes       = change_count;
        wait_speed_results(2);
        check_status(expected_status(`SPEED_10, 1'b0, 1'b0, 1'b0));
        check_flag("status_change pulse", 1'b1, change_count != changes);
        end_test();

        begin_test("inband_status");
        send_status_pair(8'hBB, 1'b1, 1'b0);  // inside a frame.
        check_status(expected_status(`SPEED_10, 1'b0, 1'b0, 1'b0));
        send_status_pair(8'hBB, 1'b0, 1'b1);  // carrier error.
        check_status(expected_status(`SPEED_10, 1'b0, 1'b0, 1'b0));
        send_status_pair(8'h3B, 1'b0, 1'b0);  // nibbles disagree.
        check_status(expected_status(`SPEED_10, 1'b0, 1'b0, 1'b0));
        // link up at 100 with full duplex, while 10 is measured.
        send_status_pair(8'hBB, 1'b0, 1'b0);
        check_status(expected_status(`SPEED_10, 1'b1, 1'b1, 1'b1));
        // same link and speed at half duplex, so link_up and full_duplex part ways.
        send_status_pair(8'h33, 1'b0, 1'b0);
        check_status(expected_status(`SPEED_10, 1'b1, 1'b0, 1'b1));
        end_test();

        begin_test("speed_mismatch");
        toggle_period = 4;
        wait_speed_results(2);
        check_status(expected_status(`SPEED_1000, 1'b1, 1'b0, 1'b1));
        changes       = change_count;
        toggle_period = 20;
        wait_speed_results(2);
        check_status(expected_status(`SPEED_100, 1'b1, 1'b0, 1'b0));
        check_flag("status_change pulse", 1'b1, change_count != changes);
        end_test();

        $display("tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, check_errors, property_errors);
        if (check_errors + property_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
